// File: include/cpuConsts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

////////////////////
// Datapath sizes
////////////////////
`define DATA_W      16  // Width of registers, instructions and bus words
`define REG_CNT     16  // Number of general registers
`define REG_ADDR_W  4   // Register index width
`define FLAG_W      5   // C, L, F, Z and N

// Instruction word fields, used as inst[`FIELD]
`define OPCODE_FIELD 15:12
`define RDEST_FIELD  11:8   // Destination, also the jump target register for JCOND
`define EXT_FIELD    7:4
`define RSRC_FIELD   3:0
`define COND_FIELD   3:0    // Shares bits with the source register
`define IMM_FIELD    7:0
`define IMM_SIGN     7      // Sign bit of the short immediate
`define IMM_W        8

////////////////////
// Opcodes
////////////////////
`define OP_REG   4'b0000  // Register to register, operation in the extended field
`define OP_MEM   4'b0100  // LOAD, STOR and JCOND
`define OP_ANDI  4'b0001
`define OP_ORI   4'b0010
`define OP_XORI  4'b0011
`define OP_ADDI  4'b0101
`define OP_SUBI  4'b1001
`define OP_CMPI  4'b1011
`define OP_MOVI  4'b1101

// Extended opcodes under OP_REG use the same codes as the immediate forms
`define EXT_AND   4'b0001
`define EXT_OR    4'b0010
`define EXT_XOR   4'b0011
`define EXT_ADD   4'b0101
`define EXT_SUB   4'b1001
`define EXT_CMP   4'b1011
`define EXT_MOV   4'b1101
// Extended opcodes under OP_MEM
`define EXT_LOAD  4'b0000
`define EXT_STOR  4'b0100
`define EXT_JCOND 4'b1100

// Branch conditions held in the low nibble of a JCOND
`define COND_JUC  4'b1110
`define COND_BEQ  4'b0000
`define COND_BNEQ 4'b0001
`define COND_BGT  4'b0110
`define COND_BLT  4'b0111
`define COND_BGE  4'b1101
`define COND_BLE  4'b1100

// Flag bit positions
`define FLAG_C 4  // Carry out of ADD
`define FLAG_L 3  // Unsigned below
`define FLAG_F 2  // Signed overflow
`define FLAG_Z 1  // Zero or equal
`define FLAG_N 0  // Signed below

`endif

// File: rtl/aluUnit.sv
`default_nettype none

`include "cpuConsts.svh"

module aluUnit (
	input  wire cpuPkg::aluOpT       aluOp,
	input  wire logic [`DATA_W-1:0]  opA,  // Destination register value
	input  wire logic [`DATA_W-1:0]  opB,  // Source register or immediate
	output logic [`DATA_W-1:0]       result,
	output logic [`FLAG_W-1:0]       flags
);

	logic [`DATA_W:0]   sum;   // One extra bit for the carry
	logic [`DATA_W-1:0] diff;
	logic               addOvf;
	logic               subOvf;
	logic               isSub;  // SUB and CMP share the subtractor

	////////////////////
	// Arithmetic
	////////////////////
	always_comb begin
		sum = {1'b0, opA} + {1'b0, opB};
		diff = opA - opB;
		// Same signs in, different sign out
		addOvf = (opA[`DATA_W-1] == opB[`DATA_W-1]) && (sum[`DATA_W-1] != opA[`DATA_W-1]);
		// Signs differ and the result takes the sign of opB
		subOvf = (opA[`DATA_W-1] != opB[`DATA_W-1]) && (diff[`DATA_W-1] != opA[`DATA_W-1]);
		isSub = (aluOp == cpuPkg::aluSub) || (aluOp == cpuPkg::aluCmp);
	end

	// Result select
	always_comb begin
		case (aluOp)
			cpuPkg::aluAdd: result = sum[`DATA_W-1:0];
			cpuPkg::aluSub: result = diff;
			cpuPkg::aluAnd: result = opA & opB;
			cpuPkg::aluOr:  result = opA | opB;
			cpuPkg::aluXor: result = opA ^ opB;
			cpuPkg::aluMov: result = opB;
			cpuPkg::aluCmp: result = diff;  // Computed but never written back
			default:        result = opB;
		endcase
	end

	////////////////////
	// Flags
	////////////////////
	always_comb begin
		flags = '0;
		flags[`FLAG_C] = (aluOp == cpuPkg::aluAdd) && sum[`DATA_W];
		flags[`FLAG_L] = opA < opB;  // Unsigned compare
		if (aluOp == cpuPkg::aluAdd) begin
			flags[`FLAG_F] = addOvf;
		end else if (isSub) begin
			flags[`FLAG_F] = subOvf;
		end
		// A compare reports equality, everything else reports a zero result
		if (aluOp == cpuPkg::aluCmp) begin
			flags[`FLAG_Z] = (opA == opB);
		end else begin
			flags[`FLAG_Z] = (result == '0);
		end
		flags[`FLAG_N] = $signed(opA) < $signed(opB);  // Signed compare
	end

endmodule

`default_nettype wire

// File: rtl/cpuCore.sv
`default_nettype none

`include "cpuConsts.svh"

module cpuCore (
	input  wire logic                 CLK,
	input  wire logic                 rstN,
	// Instruction port, data one cycle after the address
	output logic [`DATA_W-1:0]        instAddr,
	input  wire logic [`DATA_W-1:0]   inst,
	// Wishbone classic master
	output logic                      wbCyc,
	output logic                      wbStb,
	output logic                      wbWe,
	output logic [`DATA_W-1:0]        wbAdr,
	output logic [`DATA_W-1:0]        wbDatO,
	input  wire logic [`DATA_W-1:0]   wbDatI,
	input  wire logic                 wbAck
);

	cpuPkg::aluOpT        aluOp;
	logic                 useImm;
	logic                 regWrite;
	logic                 writeSelMem;
	logic                 pcInc;
	logic                 pcJump;
	logic [`FLAG_W-1:0]   aluFlags;
	logic [`DATA_W-1:0]   readDataA;  // Destination register
	logic [`DATA_W-1:0]   readDataB;  // Source register
	logic [`DATA_W-1:0]   immExt;
	logic [`DATA_W-1:0]   aluOpB;
	logic [`DATA_W-1:0]   aluResult;
	logic [`DATA_W-1:0]   writeData;

	////////////////////
	// Datapath wiring
	////////////////////
	// Short immediate widened with its sign
	assign immExt = {{(`DATA_W - `IMM_W){inst[`IMM_SIGN]}}, inst[`IMM_FIELD]};
	assign aluOpB = useImm ? immExt : readDataB;
	assign writeData = writeSelMem ? wbDatI : aluResult;  // Load data or ALU result

	// Source register addresses memory, destination register supplies store data
	assign wbAdr = readDataB;
	assign wbDatO = readDataA;

	instructionSequencer sequencer (
		.CLK(CLK),
		.rstN(rstN),
		.inst(inst),
		.aluFlags(aluFlags),
		.wbAck(wbAck),
		.aluOp(aluOp),
		.useImm(useImm),
		.regWrite(regWrite),
		.writeSelMem(writeSelMem),
		.pcInc(pcInc),
		.pcJump(pcJump),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe)
	);

	aluUnit alu (
		.aluOp(aluOp),
		.opA(readDataA),
		.opB(aluOpB),
		.result(aluResult),
		.flags(aluFlags)
	);

	registerFile regFile (
		.CLK(CLK),
		.rstN(rstN),
		.readAddrA(inst[`RDEST_FIELD]),
		.readAddrB(inst[`RSRC_FIELD]),
		.writeAddr(inst[`RDEST_FIELD]),
		.writeEn(regWrite),
		.writeData(writeData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	// JCOND keeps its condition in the low nibble, so the target sits in the destination field
	programCounter pcReg (
		.CLK(CLK),
		.rstN(rstN),
		.pcInc(pcInc),
		.pcJump(pcJump),
		.jumpTarget(readDataA),
		.pc(instAddr)
	);

endmodule

`default_nettype wire

// File: rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	////////////////////
	// Sequencer states
	////////////////////
	// An instruction starts in fetch, where the PC is presented to the ROM
	// Decode sees the returned word and picks the execute path
	typedef enum logic [2:0] {
		fetch  = 3'b000,  // Instruction address on the ROM port
		decode = 3'b001,  // ROM word valid, choose a path
		alu    = 3'b010,  // Register or immediate operation, result written here
		stor1  = 3'b011,  // Bus write held until acknowledge
		stor2  = 3'b100,  // Write done, advance the PC
		load1  = 3'b101,  // Bus read held until acknowledge, data captured on ack
		load2  = 3'b110,  // Read done, advance the PC
		jump   = 3'b111   // Condition test, PC jumps or steps
	} seqStateT;

	////////////////////
	// ALU operations
	////////////////////
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluMov,  // Passes the second operand through
		aluCmp   // Subtracts for the flags only
	} aluOpT;

endpackage

`default_nettype wire

// File: rtl/instructionSequencer.sv
`default_nettype none

`include "cpuConsts.svh"

module instructionSequencer (
	input  wire logic                 CLK,
	input  wire logic                 rstN,
	input  wire logic [`DATA_W-1:0]   inst,      // Word from the synchronous ROM
	input  wire logic [`FLAG_W-1:0]   aluFlags,  // Live flags from the ALU
	input  wire logic                 wbAck,
	output cpuPkg::aluOpT             aluOp,
	output logic                      useImm,       // Second ALU operand is the immediate
	output logic                      regWrite,
	output logic                      writeSelMem,  // Register write takes bus data
	output logic                      pcInc,
	output logic                      pcJump,
	output logic                      wbCyc,
	output logic                      wbStb,
	output logic                      wbWe
);

	cpuPkg::seqStateT state, nextState;
	logic [`FLAG_W-1:0] flagsQ;  // Flags kept for later conditional jumps
	logic               validAlu;  // Decode found a known ALU operation
	logic               condMet;   // Branch condition holds on the stored flags

	////////////////////
	// Operation decode
	////////////////////
	always_comb begin
		aluOp = cpuPkg::aluMov;
		validAlu = 1'b0;
		useImm = (inst[`OPCODE_FIELD] != `OP_REG);  // Every non-register form carries an immediate
		if (inst[`OPCODE_FIELD] == `OP_REG) begin
			validAlu = 1'b1;
			case (inst[`EXT_FIELD])
				`EXT_ADD: aluOp = cpuPkg::aluAdd;
				`EXT_SUB: aluOp = cpuPkg::aluSub;
				`EXT_AND: aluOp = cpuPkg::aluAnd;
				`EXT_OR:  aluOp = cpuPkg::aluOr;
				`EXT_XOR: aluOp = cpuPkg::aluXor;
				`EXT_MOV: aluOp = cpuPkg::aluMov;
				`EXT_CMP: aluOp = cpuPkg::aluCmp;
				default:  validAlu = 1'b0;  // Unknown extension runs as a no-op
			endcase
		end else begin
			validAlu = 1'b1;
			case (inst[`OPCODE_FIELD])
				`OP_ADDI: aluOp = cpuPkg::aluAdd;
				`OP_SUBI: aluOp = cpuPkg::aluSub;
				`OP_ANDI: aluOp = cpuPkg::aluAnd;
				`OP_ORI:  aluOp = cpuPkg::aluOr;
				`OP_XORI: aluOp = cpuPkg::aluXor;
				`OP_MOVI: aluOp = cpuPkg::aluMov;
				`OP_CMPI: aluOp = cpuPkg::aluCmp;
				default:  validAlu = 1'b0;  // Includes OP_MEM
			endcase
		end
	end

	// Branch test on the flags saved by the last storing state
	always_comb begin
		case (inst[`COND_FIELD])
			`COND_JUC:  condMet = 1'b1;
			`COND_BEQ:  condMet = flagsQ[`FLAG_Z];
			`COND_BNEQ: condMet = !flagsQ[`FLAG_Z];
			// Greater needs both below flags clear and the operands unequal
			`COND_BGT:  condMet = !flagsQ[`FLAG_L] && !flagsQ[`FLAG_N] && !flagsQ[`FLAG_Z];
			`COND_BLT:  condMet = flagsQ[`FLAG_L] || flagsQ[`FLAG_N];
			`COND_BGE:  condMet = flagsQ[`FLAG_Z] || (!flagsQ[`FLAG_L] && !flagsQ[`FLAG_N]);
			`COND_BLE:  condMet = flagsQ[`FLAG_Z] || flagsQ[`FLAG_L] || flagsQ[`FLAG_N];
			default:    condMet = 1'b0;  // Unused codes fall through
		endcase
	end

	////////////////////
	// State and flags
	////////////////////
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= cpuPkg::fetch;
			flagsQ <= '0;
		end else begin
			state <= nextState;
			// Flags are captured at the close of every finishing state
			if (state == cpuPkg::alu || state == cpuPkg::load2 ||
					state == cpuPkg::stor2 || state == cpuPkg::jump) begin
				flagsQ <= aluFlags;
			end
		end
	end

	// Next state
	always_comb begin
		nextState = cpuPkg::fetch;
		case (state)
			cpuPkg::fetch: nextState = cpuPkg::decode;
			cpuPkg::decode: begin
				nextState = cpuPkg::alu;  // Register, immediate and unknown words
				if (inst[`OPCODE_FIELD] == `OP_MEM) begin
					case (inst[`EXT_FIELD])
						`EXT_LOAD:  nextState = cpuPkg::load1;
						`EXT_STOR:  nextState = cpuPkg::stor1;
						`EXT_JCOND: nextState = cpuPkg::jump;
						default:    nextState = cpuPkg::alu;
					endcase
				end
			end
			// Bus states wait as long as the slave needs
			cpuPkg::load1: nextState = wbAck ? cpuPkg::load2 : cpuPkg::load1;
			cpuPkg::stor1: nextState = wbAck ? cpuPkg::stor2 : cpuPkg::stor1;
			default: nextState = cpuPkg::fetch;  // alu, load2, stor2 and jump all finish
		endcase
	end

	// Outputs decoded from the present state only
	always_comb begin
		regWrite = 1'b0;
		writeSelMem = 1'b0;
		pcInc = 1'b0;
		pcJump = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		case (state)
			cpuPkg::alu: begin
				pcInc = 1'b1;
				regWrite = validAlu && (aluOp != cpuPkg::aluCmp);  // Compares keep the register
			end
			cpuPkg::load1: begin
				wbCyc = 1'b1;
				wbStb = 1'b1;
				regWrite = wbAck;  // Read data lands in the ack cycle
				writeSelMem = 1'b1;
			end
			cpuPkg::stor1: begin
				wbCyc = 1'b1;
				wbStb = 1'b1;
				wbWe = 1'b1;
			end
			cpuPkg::load2, cpuPkg::stor2: pcInc = 1'b1;
			cpuPkg::jump: begin
				pcJump = condMet;
				pcInc = !condMet;
			end
			default: begin
			end
		endcase
	end

	////////////////////
	// Protocol checks
	////////////////////
	// Strobe only inside a bus cycle
	assert property (@(posedge CLK) disable iff (!rstN) wbStb |-> wbCyc);
	// The PC never steps and jumps together
	assert property (@(posedge CLK) disable iff (!rstN) !(pcInc && pcJump));
	// Direction is held while the slave stalls
	assert property (@(posedge CLK) disable iff (!rstN)
		(wbCyc && !wbAck) |=> $stable(wbWe));

endmodule

`default_nettype wire

// File: rtl/programCounter.sv
`default_nettype none

`include "cpuConsts.svh"

module programCounter (
	input  wire logic                 CLK,
	input  wire logic                 rstN,
	input  wire logic                 pcInc,
	input  wire logic                 pcJump,
	input  wire logic [`DATA_W-1:0]   jumpTarget,  // Absolute address from a register
	output logic [`DATA_W-1:0]        pc
);

	////////////////////
	// Fetch address
	////////////////////
	// The PC moves only in the last state of an instruction
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= '0;  // Execution starts at word 0
		end else if (pcJump) begin
			pc <= jumpTarget;
		end else if (pcInc) begin
			pc <= pc + `DATA_W'(1);  // Wraps at the top of the space
		end
	end

	// Jump and step come from exclusive sequencer branches
	// Taking jump first keeps a taken branch correct even so

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
`default_nettype none

`include "cpuConsts.svh"

module registerFile (
	input  wire logic                     CLK,
	input  wire logic                     rstN,
	input  wire logic [`REG_ADDR_W-1:0]   readAddrA,
	input  wire logic [`REG_ADDR_W-1:0]   readAddrB,
	input  wire logic [`REG_ADDR_W-1:0]   writeAddr,
	input  wire logic                     writeEn,
	input  wire logic [`DATA_W-1:0]       writeData,
	output logic [`DATA_W-1:0]            readDataA,
	output logic [`DATA_W-1:0]            readDataB
);

	// Register 0 is a normal register, no hardwired zero
	logic [`DATA_W-1:0] regs [`REG_CNT];

	// Write port, all registers start from zero
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Read ports are combinational
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];  // Also the bus address for LOAD and STOR

	// An unknown value would spread through every later instruction
	assert property (@(posedge CLK) disable iff (!rstN)
		writeEn |-> !$isunknown(writeData));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module cpuTb -Mdir obj_dir -o cpuSim

out=$(./obj_dir/cpuSim)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -q "^Testbench passed$"

// File: sources.f
+incdir+include
rtl/cpuPkg.sv
rtl/aluUnit.sv
rtl/registerFile.sv
rtl/programCounter.sv
rtl/instructionSequencer.sv
rtl/cpuCore.sv
tests/cpuChecker.sv
tests/cpuTb.sv

// File: tests/cpuChecker.sv
`default_nettype none

`include "cpuConsts.svh"

module cpuChecker (
	input wire logic                 CLK,
	input wire logic                 rstN,
	input wire logic [`DATA_W-1:0]   instAddr,
	input wire logic                 wbCyc,
	input wire logic                 wbStb,
	input wire logic                 wbWe,
	input wire logic [`DATA_W-1:0]   wbAdr,
	input wire logic [`DATA_W-1:0]   wbDatO,
	input wire logic                 wbAck
);

	int                 passCount = 0;
	int                 failCount = 0;
	int                 writeCount = 0;  // Completed bus writes in the running test
	int                 resetCycles = 0;
	logic [`DATA_W-1:0] lastAdr = '0;
	logic [`DATA_W-1:0] lastDat = '0;
	logic               resetBad = 1'b0;  // Bus or PC misbehaved around reset
	logic               prevRstN = 1'b0;

	////////////////////
	// Bus and reset watch
	////////////////////
	// Sampled on the falling edge where every signal has settled
	always @(negedge CLK) begin
		if (!rstN) begin
			resetCycles = resetCycles + 1;
			// The first rising edge inside reset clears the core
			if (resetCycles >= 2 &&
					(wbCyc !== 1'b0 || wbStb !== 1'b0 || instAddr !== '0)) begin
				resetBad = 1'b1;
			end
		end else begin
			if (!prevRstN && instAddr !== '0) begin
				resetBad = 1'b1;  // First fetch must come from word 0
			end
			if (wbCyc && wbStb && wbWe && wbAck) begin
				writeCount = writeCount + 1;  // Write completes in the ack cycle
				lastAdr = wbAdr;
				lastDat = wbDatO;
			end
		end
		prevRstN = rstN;
	end

	// Clears the per-test record when a new reset starts
	task automatic startTest();
		writeCount = 0;
		resetCycles = 0;
		resetBad = 1'b0;
	endtask

	// Compares the last write and the halt address with the expected values
	task automatic endTest(input string name, input logic [`DATA_W-1:0] expAdr,
			input logic [`DATA_W-1:0] expDat, input logic [`DATA_W-1:0] expHalt,
			input logic timedOut);
		logic bad;
		bad = 1'b0;
		if (timedOut) begin
			$display("%s: the program did not halt in time", name);
			bad = 1'b1;
		end else if (writeCount == 0) begin
			$display("%s: no bus write was completed", name);
			bad = 1'b1;
		end else begin
			if (lastAdr !== expAdr) begin
				$display("** Error %s: write address expected %h, actual %h", name, expAdr, lastAdr);
				bad = 1'b1;
			end
			if (lastDat !== expDat) begin
				$display("** Error %s: write data expected %h, actual %h", name, expDat, lastDat);
				bad = 1'b1;
			end
			if (instAddr !== expHalt) begin
				$display("** Error %s: halt address expected %h, actual %h", name, expHalt,
					instAddr);
				bad = 1'b1;
			end
		end
		if (resetBad) begin
			$display("%s: the bus was active or the PC was not zero around reset", name);
			bad = 1'b1;
		end
		if (bad) begin
			failCount = failCount + 1;
		end else begin
			passCount = passCount + 1;
			$display("%s: ok", name);
		end
	endtask

	// Closing line of counts
	task automatic closeRun();
		$display("%0d tests, %0d passed, %0d failed", passCount + failCount, passCount,
			failCount);
	endtask

endmodule

`default_nettype wire

// File: tests/cpuTb.sv
`default_nettype none

`include "cpuConsts.svh"

module cpuTb;

	localparam int ROWS = 13;
	localparam int PROG_W = 8;        // Words per program
	localparam int RESET_CYC = 16;
	localparam int TEST_CYC = PROG_W * 40 + RESET_CYC;  // Budget of one row
	localparam int HALT_CYC = 12;     // Longer than any instruction with bus waits
	localparam int WATCH_TIME = ROWS * TEST_CYC * 20;

	logic               CLK = 1'b0;
	logic               rstN;
	logic [`DATA_W-1:0] instAddr;
	logic [`DATA_W-1:0] inst;
	logic               wbCyc;
	logic               wbStb;
	logic               wbWe;
	logic [`DATA_W-1:0] wbAdr;
	logic [`DATA_W-1:0] wbDatO;
	logic [`DATA_W-1:0] wbDatI;
	logic               wbAck;

	logic [`DATA_W-1:0] rom [64];
	logic [`DATA_W-1:0] ram [256];
	logic [`DATA_W-1:0] romQ;
	logic               busReq, ackSeen, weQ, rstQ;
	logic [7:0]         adrQ;
	logic [`DATA_W-1:0] datQ;
	logic               busy = 1'b0;  // RAM is counting wait states
	int                 waitLeft = 0;

	// Test table
	string              names [ROWS];
	logic [`DATA_W-1:0] progs [ROWS][PROG_W];
	logic [`DATA_W-1:0] expAdr [ROWS];
	logic [`DATA_W-1:0] expDat [ROWS];
	logic [`DATA_W-1:0] expHalt [ROWS];
	int                 rowCnt = 0;

	always #10 CLK = ~CLK;

	cpuCore UUT (.CLK(CLK), .rstN(rstN), .instAddr(instAddr), .inst(inst), .wbCyc(wbCyc),
		.wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO), .wbDatI(wbDatI),
		.wbAck(wbAck));

	cpuChecker watcher (.CLK(CLK), .rstN(rstN), .instAddr(instAddr), .wbCyc(wbCyc),
		.wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO), .wbAck(wbAck));

	////////////////////
	// Memory models
	////////////////////
	always @(posedge CLK) begin
		romQ = rom[instAddr[5:0]];  // Synchronous ROM, word shows up a cycle later
		#2 inst = romQ;
	end

	// Wishbone RAM with 1 to 4 random wait cycles
	always @(posedge CLK) begin
		busReq = wbCyc && wbStb;
		ackSeen = wbAck;
		weQ = wbWe;
		adrQ = wbAdr[7:0];
		datQ = wbDatO;
		rstQ = rstN;
		#2;
		if (!rstQ || ackSeen || !busReq) begin
			wbAck = 1'b0;  // Ack lasts one cycle
			busy = 1'b0;
		end else begin
			if (!busy) begin
				busy = 1'b1;
				waitLeft = 1 + int'($urandom % 4);
			end
			waitLeft = waitLeft - 1;
			if (waitLeft == 0) begin
				wbAck = 1'b1;
				if (weQ) ram[adrQ] = datQ;
				else wbDatI = ram[adrQ];
			end
		end
	end

	////////////////////
	// Assembler
	////////////////////
	function automatic logic [15:0] immOp(input logic [3:0] op, input logic [3:0] rd,
			input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] regOp(input logic [3:0] ext, input logic [3:0] rd,
			input logic [3:0] rs);
		return {`OP_REG, rd, ext, rs};
	endfunction

	function automatic logic [15:0] memOp(input logic [3:0] ext, input logic [3:0] rd,
			input logic [3:0] rs);
		return {`OP_MEM, rd, ext, rs};
	endfunction

	// Branch outcome after CMP a,b from the flag rules Z, L (unsigned) and N (signed)
	function automatic logic branchTaken(input logic [3:0] cond, input logic [15:0] a,
			input logic [15:0] b);
		logic eq, below, sBelow;
		eq = (a == b);
		below = (a < b);
		sBelow = ($signed(a) < $signed(b));
		case (cond)
			`COND_JUC:  return 1'b1;
			`COND_BEQ:  return eq;
			`COND_BNEQ: return !eq;
			`COND_BGT:  return !below && !sBelow && !eq;
			`COND_BLT:  return below || sBelow;
			`COND_BGE:  return eq || (!below && !sBelow);
			`COND_BLE:  return eq || below || sBelow;
			default:    return 1'b0;
		endcase
	endfunction

	task automatic addRow(input string name, input logic [PROG_W*16-1:0] words,
			input logic [15:0] adr, input logic [15:0] dat, input logic [15:0] halt);
		names[rowCnt] = name;
		for (int i = 0; i < PROG_W; i++) begin
			progs[rowCnt][i] = words[PROG_W*16-1-16*i -: 16];  // Word 0 sits in the top bits
		end
		expAdr[rowCnt] = adr;
		expDat[rowCnt] = dat;
		expHalt[rowCnt] = halt;
		rowCnt = rowCnt + 1;
	endtask

	// Taken path stores the compared value at 0, fall through stores 0x77 instead
	task automatic addBranch(input string name, input logic [3:0] cond, input logic swapOps,
			input logic [7:0] v);
		logic [15:0] val, a, b;
		val = {{8{v[7]}}, v};
		a = swapOps ? val : 16'h0;
		b = swapOps ? 16'h0 : val;
		addRow(name, {immOp(`OP_MOVI, 4'd13, 8'd6), immOp(`OP_MOVI, 4'd14, 8'd7),
			immOp(`OP_MOVI, 4'd2, v),
			swapOps ? regOp(`EXT_CMP, 4'd2, 4'd0) : regOp(`EXT_CMP, 4'd0, 4'd2),
			memOp(`EXT_JCOND, 4'd13, cond), immOp(`OP_MOVI, 4'd2, 8'h77),
			memOp(`EXT_STOR, 4'd2, 4'd0), memOp(`EXT_JCOND, 4'd14, `COND_JUC)},
			16'h0, branchTaken(cond, a, b) ? val : 16'h0077, 16'd7);
	endtask

	// Store, load back into r2, store again one word higher
	task automatic addLoad(input string name, input logic [7:0] v);
		addRow(name, {immOp(`OP_MOVI, 4'd1, v), immOp(`OP_MOVI, 4'd14, 8'h20),
			memOp(`EXT_STOR, 4'd1, 4'd14), memOp(`EXT_LOAD, 4'd2, 4'd14),
			immOp(`OP_MOVI, 4'd13, 8'h21), memOp(`EXT_STOR, 4'd2, 4'd13),
			immOp(`OP_MOVI, 4'd15, 8'd7), memOp(`EXT_JCOND, 4'd15, `COND_JUC)},
			16'h0021, {{8{v[7]}}, v}, 16'd7);
	endtask

	task automatic buildTable();
		addRow("addWrap", {immOp(`OP_MOVI, 4'd1, 8'h7F), immOp(`OP_MOVI, 4'd2, 8'hFD),
			regOp(`EXT_ADD, 4'd1, 4'd2), immOp(`OP_MOVI, 4'd14, 8'h10),
			memOp(`EXT_STOR, 4'd1, 4'd14), immOp(`OP_MOVI, 4'd15, 8'd6),
			memOp(`EXT_JCOND, 4'd15, `COND_JUC), 16'h0}, 16'h0010, 16'h007F + 16'hFFFD, 16'd6);
		addRow("subMov", {immOp(`OP_MOVI, 4'd1, 8'h05), immOp(`OP_MOVI, 4'd2, 8'h09),
			regOp(`EXT_SUB, 4'd1, 4'd2), regOp(`EXT_MOV, 4'd3, 4'd1),
			immOp(`OP_MOVI, 4'd14, 8'h11), memOp(`EXT_STOR, 4'd3, 4'd14),
			immOp(`OP_MOVI, 4'd15, 8'd7), memOp(`EXT_JCOND, 4'd15, `COND_JUC)},
			16'h0011, 16'h0005 - 16'h0009, 16'd7);
		addRow("andXor", {immOp(`OP_MOVI, 4'd1, 8'h5A), immOp(`OP_MOVI, 4'd2, 8'hF0),
			regOp(`EXT_AND, 4'd1, 4'd2), regOp(`EXT_XOR, 4'd1, 4'd2),
			immOp(`OP_MOVI, 4'd14, 8'h12), memOp(`EXT_STOR, 4'd1, 4'd14),
			immOp(`OP_MOVI, 4'd15, 8'd7), memOp(`EXT_JCOND, 4'd15, `COND_JUC)},
			16'h0012, (16'h005A & 16'hFFF0) ^ 16'hFFF0, 16'd7);
		addRow("orAddi", {immOp(`OP_MOVI, 4'd1, 8'h21), immOp(`OP_MOVI, 4'd2, 8'h0C),
			regOp(`EXT_OR, 4'd1, 4'd2), immOp(`OP_ADDI, 4'd1, 8'hFF),
			immOp(`OP_MOVI, 4'd14, 8'h13), memOp(`EXT_STOR, 4'd1, 4'd14),
			immOp(`OP_MOVI, 4'd15, 8'd7), memOp(`EXT_JCOND, 4'd15, `COND_JUC)},
			16'h0013, (16'h0021 | 16'h000C) + 16'hFFFF, 16'd7);
		addRow("cmpKeep", {immOp(`OP_MOVI, 4'd1, 8'h33), immOp(`OP_MOVI, 4'd2, 8'h44),
			regOp(`EXT_CMP, 4'd1, 4'd2), immOp(`OP_CMPI, 4'd1, 8'h12),
			immOp(`OP_MOVI, 4'd14, 8'h14), memOp(`EXT_STOR, 4'd1, 4'd14),
			immOp(`OP_MOVI, 4'd15, 8'd7), memOp(`EXT_JCOND, 4'd15, `COND_JUC)},
			16'h0014, 16'h0033, 16'd7);
		addBranch("beqEqual", `COND_BEQ, 1'b0, 8'h00);
		addBranch("bneqEqual", `COND_BNEQ, 1'b0, 8'h00);
		addBranch("bgtSigned", `COND_BGT, 1'b1, 8'hFE);
		addBranch("bltBelow", `COND_BLT, 1'b0, 8'h05);
		addBranch("bgeOpposite", `COND_BGE, 1'b0, 8'hFE);
		addBranch("bleOpposite", `COND_BLE, 1'b1, 8'hFE);
		addLoad("loadPositive", 8'h5C);
		addLoad("loadNegative", 8'hA7);
	endtask

	////////////////////
	// Run control
	////////////////////
	// Holds reset for 16 cycles and loads the program meanwhile
	task automatic applyReset(input int row);
		@(posedge CLK);
		#2 rstN = 1'b0;
		watcher.startTest();
		for (int i = 0; i < 64; i++) begin
			rom[i] = (i < PROG_W) ? progs[row][i] : 16'h0;
		end
		repeat (RESET_CYC) @(posedge CLK);
		#2 rstN = 1'b1;
	endtask

	// A self jump keeps instAddr still with the bus idle
	task automatic waitHalt(output logic timedOut);
		int cycles, still;
		logic [15:0] lastPc;
		cycles = 0;
		still = 0;
		lastPc = instAddr;
		timedOut = 1'b0;
		while (still < HALT_CYC && !timedOut) begin
			@(negedge CLK);
			if (instAddr == lastPc && !wbCyc) begin
				still = still + 1;
			end else begin
				still = 0;
				lastPc = instAddr;
			end
			cycles = cycles + 1;
			if (cycles > TEST_CYC) timedOut = 1'b1;
		end
	endtask

	initial begin
		logic timedOut;
		int seedDraw;
		rstN = 1'b0;
		inst = '0;
		wbAck = 1'b0;
		wbDatI = '0;
		seedDraw = $urandom(32'he36967cf);
		for (int a = 0; a < 256; a++) begin
			ram[a] = 16'hA500 | 16'(a);  // Each word carries its own address
		end
		buildTable();
		for (int t = 0; t < rowCnt; t++) begin
			applyReset(t);
			waitHalt(timedOut);
			watcher.endTest(names[t], expAdr[t], expDat[t], expHalt[t], timedOut);
		end
		watcher.closeRun();
		if (watcher.failCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog for a core that never halts
	initial begin
		#(WATCH_TIME);
		$display("The watchdog ran out of time and stopped the run");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
